// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  // Shift amount taken from the low bits of operand b
  localparam int SHAMT_W = 5;

  // ==============================
  // Integer ALU operations
  // ==============================
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9
  } alu_op_e;

  // M extension multiply, funct3 of the R-type word
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,  // signed x signed
    MULHSU = 3'b010,  // signed x unsigned
    MULHU  = 3'b011   // unsigned x unsigned
  } mul_func_e;

  // Conditional branch funct3, B-type word
  typedef enum logic [2:0] {
    BR_BEQ  = 3'b000,
    BR_BNE  = 3'b001,
    BR_BLT  = 3'b100,
    BR_BGE  = 3'b101,
    BR_BLTU = 3'b110,
    BR_BGEU = 3'b111
  } br_funct3_e;

endpackage

`default_nettype wire

// ==== rtl/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

  // ==============================
  // Sizes of the execute block
  // ==============================
  localparam int XLEN        = 32;
  localparam int PHYS_REGS   = 128;
  localparam int ROB_DEPTH   = 64;
  localparam int MULT_STAGES = 4;   // Register stages inside the multiplier

  typedef logic [XLEN-1:0]              word_t;
  typedef logic [$clog2(PHYS_REGS)-1:0] prf_tag_t;
  typedef logic [$clog2(ROB_DEPTH)-1:0] rob_idx_t;

  // ==============================
  // Issue side requests
  // ==============================
  typedef struct packed {
    logic              valid;
    isa_pkg::alu_op_e  op;
    word_t             src1;
    word_t             src2;
    prf_tag_t          dest_tag;
    rob_idx_t          rob_idx;
  } alu_req_t;

  typedef struct packed {
    logic               valid;
    isa_pkg::mul_func_e func;
    word_t              src1;
    word_t              src2;
    prf_tag_t           dest_tag;
    rob_idx_t           rob_idx;
  } mul_req_t;

  typedef struct packed {
    logic                valid;
    logic                uncond;      // JAL or JALR
    isa_pkg::br_funct3_e funct3;
    word_t               cmp_a;
    word_t               cmp_b;
    word_t               tgt_base;    // PC, or rs1 for JALR
    word_t               tgt_off;     // Immediate
    logic                pred_taken;
    word_t               pred_pc;
    word_t               npc;
    prf_tag_t            dest_tag;
    rob_idx_t            rob_idx;
  } br_req_t;

  // Completion record, one per function unit
  typedef struct packed {
    logic     valid;
    word_t    value;
    prf_tag_t dest_tag;
    rob_idx_t rob_idx;
    logic     cond_branch;
    logic     taken;
    logic     mispred;
    logic     is_jump;
    word_t    link_value;
  } fu_resp_t;

endpackage

`default_nettype wire

// ==== rtl/alu_core.sv ====
`default_nettype none

module alu_core (
  input  isa_pkg::alu_op_e op_i,
  input  exec_pkg::word_t  a_i,
  input  exec_pkg::word_t  b_i,
  output exec_pkg::word_t  result_o
);

  import isa_pkg::*;
  import exec_pkg::*;

  logic [SHAMT_W-1:0] shamt;
  logic               lt_signed;
  logic               lt_unsigned;

  assign shamt       = b_i[SHAMT_W-1:0];  // Upper bits of b ignored
  assign lt_signed   = $signed(a_i) < $signed(b_i);
  assign lt_unsigned = a_i < b_i;

  always_comb begin
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_OR:   result_o = a_i | b_i;
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SLT:  result_o = {{(XLEN-1){1'b0}}, lt_signed};
      ALU_SLTU: result_o = {{(XLEN-1){1'b0}}, lt_unsigned};
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = word_t'($signed(a_i) >>> shamt);  // Sign fill
      default:  result_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== rtl/mult_pipe.sv ====
`default_nettype none

module mult_pipe (
  input  wire logic         clock,
  input  wire logic         reset,
  input  exec_pkg::mul_req_t req_i,
  output exec_pkg::fu_resp_t resp_o
);

  import isa_pkg::*;
  import exec_pkg::*;

  localparam int PROD_W  = 2 * XLEN;
  localparam int CHUNK_W = PROD_W / MULT_STAGES;  // Multiplier bits per stage

  // One pipeline slot, operands travel with the running sum
  typedef struct packed {
    logic              valid;
    logic              hi_sel;    // Upper word wanted
    prf_tag_t          dest_tag;
    rob_idx_t          rob_idx;
    logic [PROD_W-1:0] mcand;
    logic [PROD_W-1:0] mplier;
    logic [PROD_W-1:0] acc;
  } mul_stage_t;

  mul_stage_t stage_in [MULT_STAGES];
  mul_stage_t stage_d  [MULT_STAGES];
  mul_stage_t stage_q  [MULT_STAGES];

  logic a_signed;
  logic b_signed;

  function automatic logic [PROD_W-1:0] extend(word_t w, logic sgn);
    return sgn ? {{XLEN{w[XLEN-1]}}, w} : {{XLEN{1'b0}}, w};
  endfunction

  // MUL keeps the low word, so its extension does not matter
  assign a_signed = (req_i.func == MULH) || (req_i.func == MULHSU);
  assign b_signed = (req_i.func == MULH);

  // ==============================
  // Stage inputs
  // ==============================
  always_comb begin
    stage_in[0]          = '0;
    stage_in[0].valid    = req_i.valid;
    stage_in[0].hi_sel   = (req_i.func != MUL);
    stage_in[0].dest_tag = req_i.dest_tag;
    stage_in[0].rob_idx  = req_i.rob_idx;
    stage_in[0].mcand    = extend(req_i.src1, a_signed);
    stage_in[0].mplier   = extend(req_i.src2, b_signed);
    for (int i = 1; i < MULT_STAGES; i++) begin
      stage_in[i] = stage_q[i-1];
    end
  end

  // Each stage adds one shifted partial product, all modulo 2^PROD_W
  always_comb begin
    logic [PROD_W-1:0] partial;
    for (int i = 0; i < MULT_STAGES; i++) begin
      partial = stage_in[i].mcand * PROD_W'(stage_in[i].mplier[i*CHUNK_W +: CHUNK_W]);
      stage_d[i]     = stage_in[i];
      stage_d[i].acc = stage_in[i].acc + (partial << (i * CHUNK_W));
    end
  end

  always_ff @(posedge clock) begin
    for (int i = 0; i < MULT_STAGES; i++) begin
      stage_q[i] <= stage_d[i];
    end
    if (reset) begin
      for (int i = 0; i < MULT_STAGES; i++) begin
        stage_q[i].valid <= 1'b0;
      end
    end
  end

  // ==============================
  // Response from the last stage
  // ==============================
  always_comb begin
    resp_o          = '0;  // Branch fields stay low
    resp_o.valid    = stage_q[MULT_STAGES-1].valid;
    resp_o.dest_tag = stage_q[MULT_STAGES-1].dest_tag;
    resp_o.rob_idx  = stage_q[MULT_STAGES-1].rob_idx;
    if (stage_q[MULT_STAGES-1].hi_sel) begin
      resp_o.value = stage_q[MULT_STAGES-1].acc[PROD_W-1:XLEN];
    end else begin
      resp_o.value = stage_q[MULT_STAGES-1].acc[XLEN-1:0];
    end
  end

endmodule

`default_nettype wire

// ==== rtl/branch_resolve.sv ====
`default_nettype none

module branch_resolve (
  input  exec_pkg::br_req_t  req_i,
  output exec_pkg::fu_resp_t resp_o
);

  import isa_pkg::*;
  import exec_pkg::*;

  word_t target;
  logic  cond_true;
  logic  taken;
  logic  mispred;

  // Target adder, same datapath as the integer lane
  alu_core i_tgt_add (
    .op_i     (ALU_ADD),
    .a_i      (req_i.tgt_base),
    .b_i      (req_i.tgt_off),
    .result_o (target)
  );

  // ==============================
  // Condition evaluation
  // ==============================
  always_comb begin
    case (req_i.funct3)
      BR_BEQ:  cond_true = (req_i.cmp_a == req_i.cmp_b);
      BR_BNE:  cond_true = (req_i.cmp_a != req_i.cmp_b);
      BR_BLT:  cond_true = ($signed(req_i.cmp_a) <  $signed(req_i.cmp_b));
      BR_BGE:  cond_true = ($signed(req_i.cmp_a) >= $signed(req_i.cmp_b));
      BR_BLTU: cond_true = (req_i.cmp_a <  req_i.cmp_b);
      BR_BGEU: cond_true = (req_i.cmp_a >= req_i.cmp_b);
      default: cond_true = 1'b0;  // Reserved encodings fall through
    endcase
  end

  assign taken = req_i.uncond || cond_true;

  // Taken needs both direction and target right
  always_comb begin
    if (taken) begin
      mispred = !(req_i.pred_taken && (req_i.pred_pc == target));
    end else begin
      mispred = req_i.pred_taken;
    end
  end

  always_comb begin
    resp_o             = '0;
    resp_o.valid       = req_i.valid;
    resp_o.value       = target;
    resp_o.dest_tag    = req_i.dest_tag;
    resp_o.rob_idx     = req_i.rob_idx;
    resp_o.cond_branch = !req_i.uncond;
    resp_o.taken       = taken;
    resp_o.mispred     = req_i.valid && mispred;  // No flush from an idle slot
    resp_o.is_jump     = req_i.uncond;
    resp_o.link_value  = req_i.npc;               // Written to rd by JAL/JALR
  end

endmodule

`default_nettype wire

// ==== rtl/fu_complete.sv ====
`default_nettype none

module fu_complete (
  input  wire logic          clock,
  input  wire logic          reset,
  input  exec_pkg::alu_req_t alu_req_i,
  input  exec_pkg::word_t    alu_result_i,
  input  exec_pkg::fu_resp_t mul_resp_i,
  input  exec_pkg::fu_resp_t br_resp_i,
  output exec_pkg::fu_resp_t alu_cmp_o,
  output exec_pkg::fu_resp_t mul_cmp_o,
  output exec_pkg::fu_resp_t br_cmp_o
);

  import exec_pkg::*;

  fu_resp_t alu_resp;

  // ==============================
  // ALU record assembly
  // ==============================
  always_comb begin
    alu_resp          = '0;
    alu_resp.valid    = alu_req_i.valid;
    alu_resp.value    = alu_result_i;
    alu_resp.dest_tag = alu_req_i.dest_tag;
    alu_resp.rob_idx  = alu_req_i.rob_idx;
  end

  // ==============================
  // Completion register
  // ==============================
  always_ff @(posedge clock) begin
    if (reset) begin
      alu_cmp_o <= '0;
      mul_cmp_o <= '0;
      br_cmp_o  <= '0;  // Also drops any pending mispred
    end else begin
      alu_cmp_o <= alu_resp;
      mul_cmp_o <= mul_resp_i;
      br_cmp_o  <= br_resp_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fu_exec.sv ====
`default_nettype none

module fu_exec (
  input  wire logic          clock,
  input  wire logic          reset,
  input  exec_pkg::alu_req_t alu_req_i,
  input  exec_pkg::mul_req_t mul_req_i,
  input  exec_pkg::br_req_t  br_req_i,
  output exec_pkg::fu_resp_t alu_cmp_o,
  output exec_pkg::fu_resp_t mul_cmp_o,
  output exec_pkg::fu_resp_t br_cmp_o
);

  import exec_pkg::*;

  word_t    alu_result;
  fu_resp_t mul_resp;
  fu_resp_t br_resp;

  // ==============================
  // Function units
  // ==============================
  alu_core i_alu (
    .op_i     (alu_req_i.op),
    .a_i      (alu_req_i.src1),
    .b_i      (alu_req_i.src2),
    .result_o (alu_result)
  );

  mult_pipe i_mul (  // MULT_STAGES deep
    .clock  (clock),
    .reset  (reset),
    .req_i  (mul_req_i),
    .resp_o (mul_resp)
  );

  branch_resolve i_br (
    .req_i  (br_req_i),
    .resp_o (br_resp)
  );

  // Single register stage before the block boundary
  fu_complete i_cmp (
    .clock        (clock),
    .reset        (reset),
    .alu_req_i    (alu_req_i),
    .alu_result_i (alu_result),
    .mul_resp_i   (mul_resp),
    .br_resp_i    (br_resp),
    .alu_cmp_o    (alu_cmp_o),
    .mul_cmp_o    (mul_cmp_o),
    .br_cmp_o     (br_cmp_o)
  );

endmodule

`default_nettype wire

// ==== verif/fu_exec_sva.sv ====
`default_nettype none

module fu_exec_sva (
  input wire logic          clock,
  input wire logic          reset,
  input exec_pkg::alu_req_t alu_req_i,
  input exec_pkg::mul_req_t mul_req_i,
  input exec_pkg::fu_resp_t alu_cmp_i,
  input exec_pkg::fu_resp_t mul_cmp_i,
  input exec_pkg::fu_resp_t br_cmp_i
);

  import exec_pkg::*;

  int assert_fails = 0;  // Failure count, summed up at the end of the run

  // ==============================
  // Completion timing
  // ==============================
  a_clear_after_reset: assert property (@(posedge clock)
    $fell(reset) |-> !alu_cmp_i.valid && !mul_cmp_i.valid && !br_cmp_i.valid && !br_cmp_i.mispred)
    else begin
      $error("completion outputs not clear after reset");
      assert_fails++;
    end

  // Pipeline stages plus the completion register
  a_mul_latency: assert property (@(posedge clock) disable iff (reset)
    mul_req_i.valid |-> ##(MULT_STAGES + 1) mul_cmp_i.valid)
    else begin
      $error("multiply completion not 5 cycles after request");
      assert_fails++;
    end

  a_alu_latency: assert property (@(posedge clock) disable iff (reset)
    alu_req_i.valid |-> ##1 alu_cmp_i.valid)
    else begin
      $error("ALU completion not 1 cycle after request");
      assert_fails++;
    end

endmodule

bind fu_exec fu_exec_sva i_sva (
  .clock     (clock),
  .reset     (reset),
  .alu_req_i (alu_req_i),
  .mul_req_i (mul_req_i),
  .alu_cmp_i (alu_cmp_o),
  .mul_cmp_i (mul_cmp_o),
  .br_cmp_i  (br_cmp_o)
);

`default_nettype wire

// ==== verif/tb_fu_exec.sv ====
`default_nettype none

module tb_fu_exec;

  import isa_pkg::*;
  import exec_pkg::*;

  // Tests take about 190 cycles, limit is twice that with margin
  localparam int TIMEOUT_CYCLES = 400;

  logic     clock;
  logic     reset;
  alu_req_t alu_req;
  mul_req_t mul_req;
  br_req_t  br_req;
  fu_resp_t alu_cmp;
  fu_resp_t mul_cmp;
  fu_resp_t br_cmp;

  int    cycle_count;
  string test_name;
  int    test_errors;
  int    total_errors;
  int    tests_run;
  int    tests_failed;

  fu_exec i_dut (
    .clock     (clock),
    .reset     (reset),
    .alu_req_i (alu_req),
    .mul_req_i (mul_req),
    .br_req_i  (br_req),
    .alu_cmp_o (alu_cmp),
    .mul_cmp_o (mul_cmp),
    .br_cmp_o  (br_cmp)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin  // Watchdog
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  // ==============================
  // Reference model
  // ==============================
  function automatic word_t model_alu(alu_op_e op, word_t a, word_t b);
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a - b;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
      ALU_SLL:  return a << b[SHAMT_W-1:0];
      ALU_SRL:  return a >> b[SHAMT_W-1:0];
      ALU_SRA:  return word_t'($signed(a) >>> b[SHAMT_W-1:0]);
      default:  return '0;
    endcase
  endfunction

  function automatic word_t model_mul(mul_func_e f, word_t a, word_t b);
    longint prod;
    case (f)
      MULH:    prod = longint'($signed(a)) * longint'($signed(b));
      MULHSU:  prod = longint'($signed(a)) * longint'({32'd0, b});
      default: prod = longint'({32'd0, a}) * longint'({32'd0, b});
    endcase
    return (f == MUL) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic logic branch_holds(br_funct3_e f3, word_t a, word_t b);
    case (f3)
      BR_BEQ:  return a == b;
      BR_BNE:  return a != b;
      BR_BLT:  return $signed(a) < $signed(b);
      BR_BGE:  return $signed(a) >= $signed(b);
      BR_BLTU: return a < b;
      BR_BGEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  // ==============================
  // Helpers
  // ==============================
  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("%-16s ok", test_name);
    end else begin
      $display("%-16s %0d errors", test_name, test_errors);
      tests_failed++;
    end
  endtask

  task automatic check_word(input string what, input word_t exp, input word_t act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %h actual %h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("[FAIL] %s %s: expected %b actual %b", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  task automatic require(input logic cond, input string msg);
    if (!cond) begin
      $display("%s: %s", test_name, msg);
      test_errors++;
    end
  endtask

  // Issues one branch, checks its completion one cycle later
  task automatic resolve_branch(input logic uncond, input br_funct3_e f3, input word_t a,
                                input word_t b, input logic pred_taken, input word_t pc_skew);
    word_t target;
    logic  exp_taken;
    logic  exp_mispred;
    br_req.valid      = 1'b1;
    br_req.uncond     = uncond;
    br_req.funct3     = f3;
    br_req.cmp_a      = a;
    br_req.cmp_b      = b;
    br_req.tgt_base   = $urandom;
    br_req.tgt_off    = $urandom & 32'hffff_fffe;
    br_req.npc        = $urandom;
    br_req.dest_tag   = prf_tag_t'($urandom);
    br_req.rob_idx    = rob_idx_t'($urandom);
    target            = br_req.tgt_base + br_req.tgt_off;
    br_req.pred_taken = pred_taken;
    br_req.pred_pc    = target + pc_skew;
    exp_taken = uncond || branch_holds(f3, a, b);
    if (exp_taken) begin
      exp_mispred = !(pred_taken && (br_req.pred_pc == target));
    end else begin
      exp_mispred = pred_taken;
    end
    step();
    require(br_cmp.valid, "branch completion missing");
    check_bit("taken", exp_taken, br_cmp.taken);
    check_bit("mispred", exp_mispred, br_cmp.mispred);
    check_bit("is_jump", uncond, br_cmp.is_jump);
    check_bit("cond_branch", !uncond, br_cmp.cond_branch);
    check_word("target", target, br_cmp.value);
    check_word("link_value", br_req.npc, br_cmp.link_value);
    check_word("dest_tag", word_t'(br_req.dest_tag), word_t'(br_cmp.dest_tag));
    check_word("rob_idx", word_t'(br_req.rob_idx), word_t'(br_cmp.rob_idx));
  endtask

  // ==============================
  // Tests
  // ==============================
  task automatic test_alu_ops();
    word_t a;
    word_t b;
    begin_test("alu_ops");
    for (int i = 0; i < 10; i++) begin
      for (int k = 0; k < 3; k++) begin
        a = $urandom;
        b = $urandom;
        if (k == 1) begin
          a[XLEN-1]      = 1'b1;   // Negative first operand
          b[SHAMT_W-1:0] = 5'd31;
        end else if (k == 2) begin
          b = 32'd40;              // Shift past the word, low bits give 8
        end
        alu_req.valid    = 1'b1;
        alu_req.op       = alu_op_e'(i);
        alu_req.src1     = a;
        alu_req.src2     = b;
        alu_req.dest_tag = prf_tag_t'($urandom);
        alu_req.rob_idx  = rob_idx_t'($urandom);
        step();
        require(alu_cmp.valid, "ALU completion missing");
        check_word(alu_req.op.name(), model_alu(alu_req.op, a, b), alu_cmp.value);
        check_word("dest_tag", word_t'(alu_req.dest_tag), word_t'(alu_cmp.dest_tag));
        check_word("rob_idx", word_t'(alu_req.rob_idx), word_t'(alu_cmp.rob_idx));
      end
    end
    alu_req.valid = 1'b0;
    end_test();
  endtask

  task automatic test_mul_variants();
    word_t a_set [5];
    word_t b_set [5];
    word_t expected;
    begin_test("mul_variants");
    a_set = '{32'h8000_0000, 32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'hffff_fffe};
    b_set = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8000_0000, 32'd3};
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 5; k++) begin
        mul_req.valid    = 1'b1;
        mul_req.func     = mul_func_e'(i);
        mul_req.src1     = a_set[k];
        mul_req.src2     = b_set[k];
        mul_req.dest_tag = prf_tag_t'($urandom);
        mul_req.rob_idx  = rob_idx_t'($urandom);
        expected = model_mul(mul_req.func, a_set[k], b_set[k]);
        step();
        mul_req.valid = 1'b0;
        repeat (4) step();
        require(mul_cmp.valid, "multiply completion missing after 5 cycles");
        check_word(mul_req.func.name(), expected, mul_cmp.value);
      end
    end
    end_test();
  endtask

  task automatic test_mul_back_to_back();
    word_t    exp_val [8];
    prf_tag_t exp_tag [8];
    rob_idx_t exp_rob [8];
    begin_test("mul_b2b");
    for (int c = 0; c < 12; c++) begin
      if (c < 8) begin
        mul_req.valid    = 1'b1;
        mul_req.func     = mul_func_e'($urandom_range(3, 0));
        mul_req.src1     = $urandom;
        mul_req.src2     = $urandom;
        mul_req.dest_tag = prf_tag_t'($urandom);
        mul_req.rob_idx  = rob_idx_t'(c + 20);
        exp_val[c] = model_mul(mul_req.func, mul_req.src1, mul_req.src2);
        exp_tag[c] = mul_req.dest_tag;
        exp_rob[c] = mul_req.rob_idx;
      end else begin
        mul_req.valid = 1'b0;
      end
      step();
      if (c >= 4) begin
        require(mul_cmp.valid, "back-to-back multiply missing its cycle");
        check_word("value", exp_val[c-4], mul_cmp.value);
        check_word("dest_tag", word_t'(exp_tag[c-4]), word_t'(mul_cmp.dest_tag));
        check_word("rob_idx", word_t'(exp_rob[c-4]), word_t'(mul_cmp.rob_idx));
      end
    end
    step();
    require(!mul_cmp.valid, "extra multiply completion after the burst");
    end_test();
  endtask

  task automatic test_branch_conds();
    br_funct3_e f3_set [6];
    word_t      a_set  [4];
    word_t      b_set  [4];
    begin_test("branch_conds");
    f3_set = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
    a_set  = '{32'd7, 32'hffff_fffd, 32'd4, 32'd1};  // Equal, -3 vs 4, 4 vs -3, 1 vs 2
    b_set  = '{32'd7, 32'd4, 32'hffff_fffd, 32'd2};
    foreach (f3_set[i]) begin
      for (int k = 0; k < 4; k++) begin
        resolve_branch(1'b0, f3_set[i], a_set[k], b_set[k], 1'b0, 32'd0);
      end
    end
    br_req.valid = 1'b0;
    end_test();
  endtask

  task automatic test_mispredict();
    begin_test("mispredict");
    resolve_branch(1'b0, BR_BEQ, 32'd5, 32'd5, 1'b1, 32'd0);
    resolve_branch(1'b0, BR_BEQ, 32'd5, 32'd5, 1'b0, 32'd0);  // Wrong direction
    resolve_branch(1'b0, BR_BNE, 32'd5, 32'd5, 1'b1, 32'd0);
    resolve_branch(1'b0, BR_BNE, 32'd5, 32'd5, 1'b0, 32'd0);
    resolve_branch(1'b0, BR_BLT, 32'hffff_ffff, 32'd0, 1'b1, 32'd4);  // Wrong pred_pc
    resolve_branch(1'b1, BR_BEQ, 32'd1, 32'd2, 1'b1, 32'd0);
    resolve_branch(1'b1, BR_BEQ, 32'd1, 32'd2, 1'b1, 32'd8);
    br_req.valid = 1'b0;
    end_test();
  endtask

  task automatic test_reset_mid_run();
    begin_test("reset_mid_run");
    alu_req = '{valid: 1'b1, op: ALU_ADD, src1: 32'd1, src2: 32'd2, dest_tag: 7'd3, rob_idx: 6'd4};
    mul_req = '{valid: 1'b1, func: MULHU, src1: 32'd9, src2: 32'd9, dest_tag: 7'd5, rob_idx: 6'd6};
    br_req  = '0;
    br_req.valid      = 1'b1;
    br_req.funct3     = BR_BNE;
    br_req.pred_taken = 1'b1;  // Falls through, so mispredicted
    step();
    require(br_cmp.mispred, "mispred not raised before reset");
    reset         = 1'b1;
    alu_req.valid = 1'b0;
    mul_req.valid = 1'b0;
    br_req.valid  = 1'b0;
    step();
    reset = 1'b0;
    require(!alu_cmp.valid, "ALU valid still high after reset");
    require(!mul_cmp.valid, "multiply valid still high after reset");
    require(!br_cmp.valid, "branch valid still high after reset");
    require(!br_cmp.mispred, "mispred still high after reset");
    repeat (6) begin
      step();
      require(!mul_cmp.valid, "flushed multiply completed after reset");
    end
    end_test();
  endtask

  initial begin
    void'($urandom(32'hdc78));
    reset        = 1'b1;
    alu_req      = '0;
    mul_req      = '0;
    br_req       = '0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    test_alu_ops();
    test_mul_variants();
    test_mul_back_to_back();
    test_branch_conds();
    test_mispredict();
    test_reset_mid_run();
    if (i_dut.i_sva.assert_fails != 0) begin
      $display("%0d assertion failures", i_dut.i_sva.assert_fails);
      total_errors += i_dut.i_sva.assert_fails;
    end
    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
rtl/isa_pkg.sv
rtl/exec_pkg.sv
rtl/alu_core.sv
rtl/mult_pipe.sv
rtl/branch_resolve.sv
rtl/fu_complete.sv
rtl/fu_exec.sv
verif/fu_exec_sva.sv
verif/tb_fu_exec.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f all.f --top-module tb_fu_exec -Mdir "$OBJ" -o sim
if [ $? -ne 0 ]; then
  echo "Compile failed"
  exit 1
fi

"./$OBJ/sim" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '>>> FAIL' "$LOG"; then
  exit 1
fi
exit 0
